/* logic/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int SHAMT_W    = $clog2(XLEN);

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_idx_t;

  localparam word_t RESET_PC = '0;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_t;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } br_op_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } fetch_pkt_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    alu_op_t  alu_op;
    br_op_t   br_op;
    reg_idx_t rd;
    word_t    op_a;
    word_t    op_b;
    word_t    rs2_val;
    word_t    br_offset;
    logic     wr_en;
  } issue_pkt_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    logic     wr_en;
    reg_idx_t rd;
    word_t    value;
  } commit_t;

endpackage

/* logic/fetch_stage.sv */
module fetch_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               imem_rsp_valid_i,
  input  rv_pkg::word_t      imem_rsp_data_i,
  input  rv_pkg::redirect_t  redirect_i,
  output logic               imem_req_o,
  output rv_pkg::word_t      imem_addr_o,
  output rv_pkg::fetch_pkt_t fetch_o
);

  rv_pkg::word_t pc_q;
  rv_pkg::word_t pend_target_q;
  logic          outstanding_q;
  logic          stale_q;
  logic          boot_q;
  logic          kick_q;

  // First request after reset, then one per response
  assign imem_req_o = kick_q | imem_rsp_valid_i;

  always_comb begin
    if (redirect_i.taken) begin
      imem_addr_o = redirect_i.target;
    end else if (stale_q) begin
      imem_addr_o = pend_target_q;
    end else if (kick_q) begin
      imem_addr_o = pc_q;
    end else begin
      imem_addr_o = pc_q + rv_pkg::word_t'(4);
    end
  end

  // Stale responses and those racing a redirect are dropped
  assign fetch_o.valid = imem_rsp_valid_i & ~stale_q & ~redirect_i.taken;
  assign fetch_o.pc    = pc_q;
  assign fetch_o.instr = imem_rsp_data_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q          <= rv_pkg::RESET_PC;
      outstanding_q <= 1'b0;
      stale_q       <= 1'b0;
      boot_q        <= 1'b1;
      kick_q        <= 1'b0;
    end else begin
      boot_q <= 1'b0;
      kick_q <= boot_q;
      if (imem_req_o) begin
        pc_q <= imem_addr_o;
      end
      outstanding_q <= imem_req_o | (outstanding_q & ~imem_rsp_valid_i);
      if (imem_rsp_valid_i) begin
        stale_q <= 1'b0;
      end else if (redirect_i.taken) begin
        stale_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (redirect_i.taken) begin
      pend_target_q <= redirect_i.target;
    end
  end

  // Only one request in flight at any time
  assert property (@(posedge clk_i) disable iff (!rst_i)
    imem_req_o |-> !outstanding_q || imem_rsp_valid_i);
  assert property (@(posedge clk_i) disable iff (!rst_i)
    imem_rsp_valid_i |-> outstanding_q);

endmodule

/* logic/decode_stage.sv */
module decode_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  rv_pkg::fetch_pkt_t fetch_i,
  input  rv_pkg::redirect_t  redirect_i,
  input  rv_pkg::word_t      rs1_data_i,
  input  rv_pkg::word_t      rs2_data_i,
  input  logic               wb_en_i,
  input  rv_pkg::reg_idx_t   wb_rd_i,
  input  rv_pkg::word_t      wb_value_i,
  output rv_pkg::reg_idx_t   rs1_o,
  output rv_pkg::reg_idx_t   rs2_o,
  output rv_pkg::issue_pkt_t issue_o
);

  rv_pkg::fetch_pkt_t dec_q;
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  rv_pkg::word_t      imm_i;
  rv_pkg::word_t      imm_u;
  rv_pkg::word_t      imm_b;
  rv_pkg::word_t      fwd_a;
  rv_pkg::word_t      fwd_b;

  function automatic rv_pkg::alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  return rv_pkg::ALU_SLL;
      3'b010:  return rv_pkg::ALU_SLT;
      3'b011:  return rv_pkg::ALU_SLTU;
      3'b100:  return rv_pkg::ALU_XOR;
      3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  return rv_pkg::ALU_OR;
      default: return rv_pkg::ALU_AND;
    endcase
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      dec_q.valid <= 1'b0;
    end else begin
      dec_q       <= fetch_i;
      dec_q.valid <= fetch_i.valid & ~redirect_i.taken;
    end
  end

  assign opcode = dec_q.instr[6:0];
  assign funct3 = dec_q.instr[14:12];
  assign rs1_o  = dec_q.instr[19:15];
  assign rs2_o  = dec_q.instr[24:20];
  assign imm_i  = {{20{dec_q.instr[31]}}, dec_q.instr[31:20]};
  assign imm_u  = {dec_q.instr[31:12], 12'b0};
  assign imm_b  = {{19{dec_q.instr[31]}}, dec_q.instr[31], dec_q.instr[7],
                   dec_q.instr[30:25], dec_q.instr[11:8], 1'b0};

  // Bypass the value the ALU writes this cycle
  assign fwd_a = (wb_en_i && wb_rd_i == rs1_o && rs1_o != '0) ? wb_value_i : rs1_data_i;
  assign fwd_b = (wb_en_i && wb_rd_i == rs2_o && rs2_o != '0) ? wb_value_i : rs2_data_i;

  always_comb begin
    issue_o.valid     = dec_q.valid & ~redirect_i.taken;
    issue_o.pc        = dec_q.pc;
    issue_o.alu_op    = rv_pkg::ALU_ADD;
    issue_o.br_op     = rv_pkg::BR_NONE;
    issue_o.rd        = '0;
    issue_o.op_a      = fwd_a;
    issue_o.op_b      = fwd_b;
    issue_o.rs2_val   = fwd_b;
    issue_o.br_offset = imm_b;
    issue_o.wr_en     = 1'b0;
    case (opcode)
      rv_pkg::OPC_OP: begin
        issue_o.alu_op = alu_decode(funct3, dec_q.instr[30]);
        issue_o.rd     = dec_q.instr[11:7];
        issue_o.wr_en  = 1'b1;
      end
      rv_pkg::OPC_OP_IMM: begin
        // Only the right shifts carry the funct7 alternate bit
        issue_o.alu_op = alu_decode(funct3, dec_q.instr[30] && funct3 == 3'b101);
        issue_o.op_b   = imm_i;
        issue_o.rd     = dec_q.instr[11:7];
        issue_o.wr_en  = 1'b1;
      end
      rv_pkg::OPC_LUI: begin
        issue_o.alu_op = rv_pkg::ALU_PASS_B;
        issue_o.op_b   = imm_u;
        issue_o.rd     = dec_q.instr[11:7];
        issue_o.wr_en  = 1'b1;
      end
      rv_pkg::OPC_BRANCH: begin
        case (funct3)
          3'b000:  issue_o.br_op = rv_pkg::BR_EQ;
          3'b001:  issue_o.br_op = rv_pkg::BR_NE;
          3'b100:  issue_o.br_op = rv_pkg::BR_LT;
          3'b101:  issue_o.br_op = rv_pkg::BR_GE;
          3'b110:  issue_o.br_op = rv_pkg::BR_LTU;
          3'b111:  issue_o.br_op = rv_pkg::BR_GEU;
          default: issue_o.br_op = rv_pkg::BR_NONE;
        endcase
      end
      default: begin
      end
    endcase
  end

  // Branch shadow never reaches the ALU
  assert property (@(posedge clk_i) disable iff (!rst_i)
    redirect_i.taken |=> !issue_o.valid);

endmodule

/* logic/alu_stage.sv */
module alu_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  rv_pkg::issue_pkt_t issue_i,
  output logic               wb_en_o,
  output rv_pkg::reg_idx_t   wb_rd_o,
  output rv_pkg::word_t      wb_value_o,
  output rv_pkg::redirect_t  redirect_o,
  output rv_pkg::commit_t    commit_o
);

  rv_pkg::issue_pkt_t           ex_q;
  rv_pkg::word_t                result;
  logic [rv_pkg::SHAMT_W-1:0]   shamt;
  logic                         br_taken;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      ex_q.valid <= 1'b0;
    end else begin
      ex_q <= issue_i;
    end
  end

  assign shamt = ex_q.op_b[rv_pkg::SHAMT_W-1:0];

  always_comb begin
    case (ex_q.alu_op)
      rv_pkg::ALU_ADD:    result = ex_q.op_a + ex_q.op_b;
      rv_pkg::ALU_SUB:    result = ex_q.op_a - ex_q.op_b;
      rv_pkg::ALU_SLL:    result = ex_q.op_a << shamt;
      rv_pkg::ALU_SLT: begin
        result = {{(rv_pkg::XLEN-1){1'b0}}, $signed(ex_q.op_a) < $signed(ex_q.op_b)};
      end
      rv_pkg::ALU_SLTU:   result = {{(rv_pkg::XLEN-1){1'b0}}, ex_q.op_a < ex_q.op_b};
      rv_pkg::ALU_XOR:    result = ex_q.op_a ^ ex_q.op_b;
      rv_pkg::ALU_SRL:    result = ex_q.op_a >> shamt;
      rv_pkg::ALU_SRA:    result = rv_pkg::word_t'($signed(ex_q.op_a) >>> shamt);
      rv_pkg::ALU_OR:     result = ex_q.op_a | ex_q.op_b;
      rv_pkg::ALU_AND:    result = ex_q.op_a & ex_q.op_b;
      rv_pkg::ALU_PASS_B: result = ex_q.op_b;
      default:            result = '0;
    endcase
  end

  // Branch compare on rs1 against rs2
  always_comb begin
    case (ex_q.br_op)
      rv_pkg::BR_EQ:  br_taken = ex_q.op_a == ex_q.rs2_val;
      rv_pkg::BR_NE:  br_taken = ex_q.op_a != ex_q.rs2_val;
      rv_pkg::BR_LT:  br_taken = $signed(ex_q.op_a) < $signed(ex_q.rs2_val);
      rv_pkg::BR_GE:  br_taken = $signed(ex_q.op_a) >= $signed(ex_q.rs2_val);
      rv_pkg::BR_LTU: br_taken = ex_q.op_a < ex_q.rs2_val;
      rv_pkg::BR_GEU: br_taken = ex_q.op_a >= ex_q.rs2_val;
      default:        br_taken = 1'b0;
    endcase
  end

  assign redirect_o.taken  = ex_q.valid & br_taken;
  assign redirect_o.target = ex_q.pc + ex_q.br_offset;

  // x0 is never written
  assign wb_en_o    = ex_q.valid & ex_q.wr_en & (ex_q.rd != '0);
  assign wb_rd_o    = ex_q.rd;
  assign wb_value_o = result;

  assign commit_o.valid = ex_q.valid;
  assign commit_o.pc    = ex_q.pc;
  assign commit_o.wr_en = wb_en_o;
  assign commit_o.rd    = ex_q.rd;
  assign commit_o.value = wb_en_o ? result : '0;

  assert property (@(posedge clk_i) disable iff (!rst_i)
    redirect_o.taken |-> ex_q.valid && ex_q.br_op != rv_pkg::BR_NONE && !ex_q.wr_en);

endmodule

/* logic/reg_bank.sv */
module reg_bank (
  input  logic             clk_i,
  input  logic             rst_i,
  input  rv_pkg::reg_idx_t rd_a_i,
  input  rv_pkg::reg_idx_t rd_b_i,
  input  logic             wr_en_i,
  input  rv_pkg::reg_idx_t wr_rd_i,
  input  rv_pkg::word_t    wr_data_i,
  output rv_pkg::word_t    rd_a_data_o,
  output rv_pkg::word_t    rd_b_data_o
);

  rv_pkg::word_t regs_q [rv_pkg::NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && wr_rd_i != '0) begin
      regs_q[wr_rd_i] <= wr_data_i;
    end
  end

  // x0 hardwired to zero
  assign rd_a_data_o = (rd_a_i == '0) ? '0 : regs_q[rd_a_i];
  assign rd_b_data_o = (rd_b_i == '0) ? '0 : regs_q[rd_b_i];

endmodule

/* logic/rv_core.sv */
module rv_core (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            imem_rsp_valid_i,
  input  rv_pkg::word_t   imem_rsp_data_i,
  output logic            imem_req_o,
  output rv_pkg::word_t   imem_addr_o,
  output rv_pkg::commit_t commit_o
);

  rv_pkg::fetch_pkt_t fetch_pkt;
  rv_pkg::issue_pkt_t issue_pkt;
  rv_pkg::redirect_t  redirect;
  rv_pkg::reg_idx_t   rs1_idx;
  rv_pkg::reg_idx_t   rs2_idx;
  rv_pkg::word_t      rs1_data;
  rv_pkg::word_t      rs2_data;
  logic               wb_en;
  rv_pkg::reg_idx_t   wb_rd;
  rv_pkg::word_t      wb_value;

  fetch_stage fetch_stage_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .imem_rsp_valid_i (imem_rsp_valid_i),
    .imem_rsp_data_i  (imem_rsp_data_i),
    .redirect_i       (redirect),
    .imem_req_o       (imem_req_o),
    .imem_addr_o      (imem_addr_o),
    .fetch_o          (fetch_pkt)
  );

  decode_stage decode_stage_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .fetch_i    (fetch_pkt),
    .redirect_i (redirect),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .wb_en_i    (wb_en),
    .wb_rd_i    (wb_rd),
    .wb_value_i (wb_value),
    .rs1_o      (rs1_idx),
    .rs2_o      (rs2_idx),
    .issue_o    (issue_pkt)
  );

  alu_stage alu_stage_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .issue_i    (issue_pkt),
    .wb_en_o    (wb_en),
    .wb_rd_o    (wb_rd),
    .wb_value_o (wb_value),
    .redirect_o (redirect),
    .commit_o   (commit_o)
  );

  // ALU writes back directly
  reg_bank reg_bank_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rd_a_i      (rs1_idx),
    .rd_b_i      (rs2_idx),
    .wr_en_i     (wb_en),
    .wr_rd_i     (wb_rd),
    .wr_data_i   (wb_value),
    .rd_a_data_o (rs1_data),
    .rd_b_data_o (rs2_data)
  );

endmodule

/* test/program_table.svh */
localparam int PROG_DEPTH = 64;
localparam int EXP_LEN    = 40;

// Forwarding chain runs with memory latency forced to 1
localparam rv_pkg::word_t FAST_LO = 32'd92;
localparam rv_pkg::word_t FAST_HI = 32'd115;

rv_pkg::word_t   prog_words  [PROG_DEPTH];
rv_pkg::commit_t exp_commits [EXP_LEN];

function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic rv_pkg::word_t imm_op(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
  return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic rv_pkg::word_t lui_word(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, 7'b0110111};
endfunction

function automatic rv_pkg::word_t branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

// Unused words hold a custom-0 opcode built from the address
function automatic rv_pkg::word_t fill_word(input rv_pkg::word_t addr);
  return {addr[26:2] ^ {18'b0, addr[31:27], addr[1:0]}, 7'b0001011};
endfunction

// Branches and x0 writes commit with rd zero, which means no write
function automatic rv_pkg::commit_t commit_rec(input rv_pkg::word_t pc,
                                               input rv_pkg::reg_idx_t rd,
                                               input rv_pkg::word_t value);
  rv_pkg::commit_t c;
  c.valid = 1'b1;
  c.pc    = pc;
  c.wr_en = (rd != 5'd0);
  c.rd    = rd;
  c.value = value;
  return c;
endfunction

task automatic load_program();
  for (int i = 0; i < PROG_DEPTH; i++) begin
    prog_words[i] = fill_word(rv_pkg::word_t'(i * 4));
  end
  // Register-register ops
  prog_words[0]  = imm_op(12'h005, 5'd0, 3'd0, 5'd1);
  prog_words[1]  = imm_op(12'hFFD, 5'd0, 3'd0, 5'd2);
  prog_words[2]  = r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3);
  prog_words[3]  = r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd4);
  prog_words[4]  = r_type(7'h00, 5'd1, 5'd2, 3'd2, 5'd5);
  prog_words[5]  = r_type(7'h00, 5'd1, 5'd2, 3'd3, 5'd6);
  prog_words[6]  = r_type(7'h20, 5'd1, 5'd2, 3'd5, 5'd7);
  prog_words[7]  = r_type(7'h00, 5'd1, 5'd2, 3'd5, 5'd8);
  prog_words[8]  = r_type(7'h00, 5'd1, 5'd1, 3'd1, 5'd9);
  prog_words[9]  = r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd10);
  prog_words[10] = r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd11);
  prog_words[11] = r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd12);
  prog_words[12] = r_type(7'h00, 5'd1, 5'd1, 3'd0, 5'd0);
  prog_words[13] = r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd13);
  // Immediate ops and LUI
  prog_words[14] = lui_word(20'h80001, 5'd14);
  prog_words[15] = imm_op(12'hFFF, 5'd1, 3'd4, 5'd15);
  prog_words[16] = imm_op(12'h7F0, 5'd1, 3'd6, 5'd16);
  prog_words[17] = imm_op(12'h0F0, 5'd2, 3'd7, 5'd17);
  prog_words[18] = imm_op(12'hFFE, 5'd2, 3'd2, 5'd18);
  prog_words[19] = imm_op(12'hFFF, 5'd1, 3'd3, 5'd19);
  prog_words[20] = imm_op(12'h004, 5'd1, 3'd1, 5'd20);
  prog_words[21] = imm_op(12'h01C, 5'd2, 3'd5, 5'd21);
  prog_words[22] = imm_op(12'h401, 5'd2, 3'd5, 5'd22);
  // Dependent chain
  prog_words[23] = imm_op(12'h001, 5'd0, 3'd0, 5'd23);
  prog_words[24] = r_type(7'h00, 5'd23, 5'd23, 3'd0, 5'd23);
  prog_words[25] = r_type(7'h00, 5'd23, 5'd23, 3'd0, 5'd23);
  prog_words[26] = imm_op(12'h002, 5'd23, 3'd1, 5'd24);
  prog_words[27] = r_type(7'h20, 5'd23, 5'd24, 3'd0, 5'd25);
  prog_words[28] = r_type(7'h00, 5'd24, 5'd25, 3'd0, 5'd26);
  // Branches
  // Shadow slots write 99 to x27 if they leak
  prog_words[29] = branch_word(13'd8, 5'd13, 5'd1, 3'd0);
  prog_words[30] = imm_op(12'd99, 5'd0, 3'd0, 5'd27);
  prog_words[31] = branch_word(13'd8, 5'd13, 5'd1, 3'd1);
  prog_words[32] = branch_word(13'd8, 5'd1, 5'd2, 3'd4);
  prog_words[33] = imm_op(12'd99, 5'd0, 3'd0, 5'd27);
  prog_words[34] = branch_word(13'd8, 5'd2, 5'd1, 3'd5);
  prog_words[35] = imm_op(12'd99, 5'd0, 3'd0, 5'd27);
  prog_words[36] = branch_word(13'd8, 5'd1, 5'd2, 3'd6);
  prog_words[37] = branch_word(13'd8, 5'd1, 5'd2, 3'd7);
  prog_words[38] = imm_op(12'd99, 5'd0, 3'd0, 5'd27);
  prog_words[39] = branch_word(13'd8, 5'd2, 5'd1, 3'd4);
  prog_words[40] = imm_op(12'd7, 5'd0, 3'd0, 5'd27);
  prog_words[41] = branch_word(13'd0, 5'd0, 5'd0, 3'd0);
endtask

task automatic load_expected();
  exp_commits[0]  = commit_rec(32'd0,   5'd1,  32'h0000_0005);
  exp_commits[1]  = commit_rec(32'd4,   5'd2,  32'hFFFF_FFFD);
  exp_commits[2]  = commit_rec(32'd8,   5'd3,  32'h0000_0002);
  exp_commits[3]  = commit_rec(32'd12,  5'd4,  32'h0000_0008);
  exp_commits[4]  = commit_rec(32'd16,  5'd5,  32'h0000_0001);
  exp_commits[5]  = commit_rec(32'd20,  5'd6,  32'h0000_0000);
  exp_commits[6]  = commit_rec(32'd24,  5'd7,  32'hFFFF_FFFF);
  exp_commits[7]  = commit_rec(32'd28,  5'd8,  32'h07FF_FFFF);
  exp_commits[8]  = commit_rec(32'd32,  5'd9,  32'h0000_00A0);
  exp_commits[9]  = commit_rec(32'd36,  5'd10, 32'hFFFF_FFF8);
  exp_commits[10] = commit_rec(32'd40,  5'd11, 32'hFFFF_FFFD);
  exp_commits[11] = commit_rec(32'd44,  5'd12, 32'h0000_0005);
  exp_commits[12] = commit_rec(32'd48,  5'd0,  32'h0000_0000);
  exp_commits[13] = commit_rec(32'd52,  5'd13, 32'h0000_0005);
  exp_commits[14] = commit_rec(32'd56,  5'd14, 32'h8000_1000);
  exp_commits[15] = commit_rec(32'd60,  5'd15, 32'hFFFF_FFFA);
  exp_commits[16] = commit_rec(32'd64,  5'd16, 32'h0000_07F5);
  exp_commits[17] = commit_rec(32'd68,  5'd17, 32'h0000_00F0);
  exp_commits[18] = commit_rec(32'd72,  5'd18, 32'h0000_0001);
  exp_commits[19] = commit_rec(32'd76,  5'd19, 32'h0000_0001);
  exp_commits[20] = commit_rec(32'd80,  5'd20, 32'h0000_0050);
  exp_commits[21] = commit_rec(32'd84,  5'd21, 32'h0000_000F);
  exp_commits[22] = commit_rec(32'd88,  5'd22, 32'hFFFF_FFFE);
  exp_commits[23] = commit_rec(32'd92,  5'd23, 32'h0000_0001);
  exp_commits[24] = commit_rec(32'd96,  5'd23, 32'h0000_0002);
  exp_commits[25] = commit_rec(32'd100, 5'd23, 32'h0000_0004);
  exp_commits[26] = commit_rec(32'd104, 5'd24, 32'h0000_0010);
  exp_commits[27] = commit_rec(32'd108, 5'd25, 32'h0000_000C);
  exp_commits[28] = commit_rec(32'd112, 5'd26, 32'h0000_001C);
  exp_commits[29] = commit_rec(32'd116, 5'd0,  32'h0000_0000);
  exp_commits[30] = commit_rec(32'd124, 5'd0,  32'h0000_0000);
  exp_commits[31] = commit_rec(32'd128, 5'd0,  32'h0000_0000);
  exp_commits[32] = commit_rec(32'd136, 5'd0,  32'h0000_0000);
  exp_commits[33] = commit_rec(32'd144, 5'd0,  32'h0000_0000);
  exp_commits[34] = commit_rec(32'd148, 5'd0,  32'h0000_0000);
  exp_commits[35] = commit_rec(32'd156, 5'd0,  32'h0000_0000);
  exp_commits[36] = commit_rec(32'd160, 5'd27, 32'h0000_0007);
  exp_commits[37] = commit_rec(32'd164, 5'd0,  32'h0000_0000);
  exp_commits[38] = commit_rec(32'd164, 5'd0,  32'h0000_0000);
  exp_commits[39] = commit_rec(32'd164, 5'd0,  32'h0000_0000);
endtask

/* test/rv_core_tb.sv */
module rv_core_tb;

  logic            clk_i;
  logic            rst_i = 1'b0;
  logic            imem_rsp_valid_i = 1'b0;
  rv_pkg::word_t   imem_rsp_data_i = '0;
  logic            imem_req_o;
  rv_pkg::word_t   imem_addr_o;
  rv_pkg::commit_t commit_o;

  int            errors = 0;
  int            mon_idx = 0;
  logic          reset_seen = 1'b0;
  logic          busy = 1'b0;
  logic          want_addr = 1'b0;
  rv_pkg::word_t next_addr = '0;
  rv_pkg::word_t req_addr = '0;
  logic [31:0]   rnd = 32'd72;
  logic [2:0]    countdown = 3'd0;

  `include "program_table.svh"

  rv_core rv_core_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .imem_rsp_valid_i (imem_rsp_valid_i),
    .imem_rsp_data_i  (imem_rsp_data_i),
    .imem_req_o       (imem_req_o),
    .imem_addr_o      (imem_addr_o),
    .commit_o         (commit_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic rv_pkg::word_t mem_read(input rv_pkg::word_t addr);
    if (addr < 32'd256) begin
      return prog_words[addr[7:2]];
    end
    return fill_word(addr);
  endfunction

  task automatic check_commit(input int idx, input rv_pkg::commit_t got,
                              input rv_pkg::commit_t want);
    if (got.pc !== want.pc) begin
      errors++;
      $display("CHECK FAILED commit[%0d].pc got %h exp %h", idx, got.pc, want.pc);
    end
    if (got.wr_en !== want.wr_en) begin
      errors++;
      $display("CHECK FAILED commit[%0d].wr_en got %h exp %h", idx, got.wr_en, want.wr_en);
    end
    if (got.rd !== want.rd) begin
      errors++;
      $display("CHECK FAILED commit[%0d].rd got %h exp %h", idx, got.rd, want.rd);
    end
    if (got.value !== want.value) begin
      errors++;
      $display("CHECK FAILED commit[%0d].value got %h exp %h", idx, got.value, want.value);
    end
  endtask

  task automatic check_addr(input rv_pkg::word_t got, input rv_pkg::word_t want);
    if (got !== want) begin
      errors++;
      $display("CHECK FAILED imem_addr_o got %h exp %h", got, want);
    end
  endtask

  // Memory model and request tracking
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (reset_seen && (imem_req_o !== 1'b0 || commit_o.valid !== 1'b0)) begin
        errors++;
        $display("Request or commit seen while reset was asserted");
      end
      reset_seen = 1'b1;
      busy = 1'b0;
      want_addr = 1'b1;
      next_addr = rv_pkg::RESET_PC;
      imem_rsp_valid_i <= 1'b0;
    end else begin
      // A jump in the expected pc sequence means a taken branch
      if (commit_o.valid) begin
        if (mon_idx + 1 < EXP_LEN &&
            exp_commits[mon_idx + 1].pc != exp_commits[mon_idx].pc + 32'd4) begin
          want_addr = 1'b1;
          next_addr = exp_commits[mon_idx + 1].pc;
        end
        mon_idx++;
      end
      imem_rsp_valid_i <= 1'b0;
      if (imem_req_o) begin
        if (busy) begin
          errors++;
          $display("Request issued while another was still outstanding");
        end
        if (want_addr) begin
          check_addr(imem_addr_o, next_addr);
          want_addr = 1'b0;
        end
        req_addr = imem_addr_o;
        busy = 1'b1;
        rnd = xorshift(rnd);
        if (req_addr >= FAST_LO && req_addr <= FAST_HI) begin
          countdown = 3'd1;
        end else begin
          countdown = 3'd1 + {1'b0, rnd[1:0]};
        end
      end
      if (busy) begin
        countdown = countdown - 3'd1;
        if (countdown == 3'd0) begin
          imem_rsp_valid_i <= 1'b1;
          imem_rsp_data_i <= mem_read(req_addr);
          busy = 1'b0;
        end
      end
    end
  end

  initial begin
    repeat (EXP_LEN * 12 + 54) @(posedge clk_i);
    $display("Watchdog expired, commits stopped arriving");
    $display("Errors: %0d", errors + 1);
    $display("Test failures found");
    $finish;
  end

  initial begin
    load_program();
    load_expected();
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b1;
    for (int i = 0; i < EXP_LEN; i++) begin
      do begin
        @(posedge clk_i);
      end while (commit_o.valid !== 1'b1);
      check_commit(i, commit_o, exp_commits[i]);
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+test
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/alu_stage.sv
logic/reg_bank.sv
logic/rv_core.sv
test/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/rv_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
  exit 0
fi
exit 1
